//--- all.f
+incdir+include
rtl/ds_pkg.sv
rtl/ds_latch.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_forward.sv
rtl/branch_resolve.sv
rtl/id_stage.sv
tb/id_stage_sva.sv
tb/id_stage_tb.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - include
    files:
      - rtl/ds_pkg.sv
      - rtl/ds_latch.sv
      - rtl/inst_decoder.sv
      - rtl/regfile.sv
      - rtl/operand_forward.sv
      - rtl/branch_resolve.sv
      - rtl/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/id_stage_sva.sv
      - tb/id_stage_tb.sv

//--- tb/id_stage_tb.sv
`timescale 1ns/10ps
`include "ds_macros.svh"

module id_stage_tb import ds_pkg::*; ();

  localparam int RST_CYCLES = 4;
  localparam int N_READS = 24;
  localparam int N_BRANCH = 28;
  // reset, register fill, reads, decode, forwarding, stalls, branches, back-pressure
  localparam int TEST_CYCLES = RST_CYCLES + 1 + `DS_REG_NUM + 2 * (N_READS + 1) + 2 * 9 +
                               2 * 9 + 12 + 3 * N_BRANCH + 8;
  localparam int MARGIN_CYCLES = 50;

  logic      clk;
  logic      rst_n;
  logic      fs_to_ds_valid;
  fs_to_ds_t fs_to_ds;
  logic      ds_allowin;
  logic      ds_to_es_valid;
  ds_to_es_t ds_to_es;
  logic      es_allowin;
  br_t       br;
  wb_t       wb;
  fwd_t      es_fwd;
  fwd_t      ms_fwd;

  word_t seed;
  word_t rf_mirror [`DS_REG_NUM];

  id_stage id_stage_i (.*);

  bind id_stage id_stage_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .fs_to_ds_valid (fs_to_ds_valid),
    .fs_to_ds       (fs_to_ds),
    .es_allowin     (es_allowin),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es       (ds_to_es),
    .br             (br),
    .ds_valid       (ds_valid),
    .stall          (stall),
    .ds_bus         (ds_bus)
  );

  always #4 clk = ~clk;

  // register file model that follows writeback
  always @(posedge clk) begin
    if (wb.we && wb.waddr != '0) begin
      rf_mirror[wb.waddr] <= wb.wdata;
    end
  end

  function automatic word_t lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic inst_t enc_rr(logic [4:0] op, reg_idx_t rk, reg_idx_t rj, reg_idx_t rd);
    return {`DS_OP_ALU_RR, op, rk, rj, rd};
  endfunction

  function automatic inst_t enc_i12(logic [5:0] grp, logic [3:0] op, logic [11:0] i12,
                                    reg_idx_t rj, reg_idx_t rd);
    return {grp, op, i12, rj, rd};
  endfunction

  function automatic inst_t enc_i26(logic [5:0] op, logic [25:0] i26);
    return {op, i26[15:0], i26[25:16]};
  endfunction

  task automatic fail_stop();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: expected %h, got %h", name, exp, got);
      fail_stop();
    end
  endtask

  task automatic clear_sources();
    es_fwd = '0;
    ms_fwd = '0;
    wb = '0;
  endtask

  // returns on the falling edge after the instruction was taken in
  task automatic load(input word_t pc_val, input inst_t inst_word);
    @(negedge clk);
    clear_sources();
    fs_to_ds_valid = 1'b1;
    fs_to_ds = '{pc: pc_val, inst: inst_word};
    #2;
    while (!ds_allowin) begin
      @(negedge clk);
      #2;
    end
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
  endtask

  task automatic check_reads(input reg_idx_t rj, input reg_idx_t rk);
    load(32'h1c00_0000, enc_rr(5'h00, rk, rj, 5'd4));
    #2;
    check_word("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_word("rj_value", ds_to_es.rj_value, (rj == '0) ? '0 : rf_mirror[rj]);
    check_word("rkd_value", ds_to_es.rkd_value, (rk == '0) ? '0 : rf_mirror[rk]);
  endtask

  task automatic check_decode(input inst_t inst_word, input word_t imm, input alu_op_t op,
                              input logic src2_imm, input logic we);
    load(32'h1c00_1000, inst_word);
    #2;
    check_word("imm", ds_to_es.imm, imm);
    check_word("alu_op", ds_to_es.alu_op, op);
    check_word("src2_is_imm", ds_to_es.src2_is_imm, src2_imm);
    check_word("gr_we", ds_to_es.gr_we, we);
  endtask

  // add.w r7, r5, r6 with r5 offered by the enabled producers
  task automatic check_forward(input logic es_on, input logic ms_on, input logic wb_on);
    word_t a;
    word_t b;
    word_t c;
    word_t exp;
    a = lcg_next();
    b = lcg_next();
    c = lcg_next();
    load(32'h1c00_2000, enc_rr(5'h00, 5'd6, 5'd5, 5'd7));
    es_fwd = '{busy: 1'b0, enable: es_on, dest: 5'd5, data: a};
    // a busy memory stage is hidden behind a ready execute match
    ms_fwd = '{busy: es_on, enable: ms_on, dest: 5'd5, data: b};
    wb = '{we: wb_on, waddr: 5'd5, wdata: c};
    if (es_on) begin
      exp = a;
    end else if (ms_on) begin
      exp = b;
    end else if (wb_on) begin
      exp = c;
    end else begin
      exp = rf_mirror[5];
    end
    #2;
    check_word("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_word("rj_value", ds_to_es.rj_value, exp);
    check_word("rkd_value", ds_to_es.rkd_value, rf_mirror[6]);
  endtask

  task automatic check_r0_forward();
    load(32'h1c00_2100, enc_rr(5'h00, 5'd0, 5'd0, 5'd3));
    es_fwd = '{busy: 1'b1, enable: 1'b1, dest: 5'd0, data: lcg_next()};
    #2;
    check_word("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_word("rj_value", ds_to_es.rj_value, '0);
  endtask

  task automatic check_stall(input logic from_ms);
    word_t d;
    d = lcg_next();
    load(32'h1c00_3000, enc_rr(5'h00, 5'd9, 5'd8, 5'd10));
    if (from_ms) begin
      ms_fwd = '{busy: 1'b1, enable: 1'b1, dest: 5'd9, data: d};
    end else begin
      es_fwd = '{busy: 1'b1, enable: 1'b1, dest: 5'd9, data: d};
    end
    repeat (3) begin
      #2;
      check_word("ds_to_es_valid", ds_to_es_valid, 1'b0);
      check_word("ds_allowin", ds_allowin, 1'b0);
      @(negedge clk);
    end
    es_fwd.busy = 1'b0;
    ms_fwd.busy = 1'b0;
    #2;
    check_word("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_word("rkd_value", ds_to_es.rkd_value, d);
  endtask

  // kind 0..5 are beq bne blt bge bltu bgeu, 6 is jirl
  task automatic check_branch(input int kind);
    word_t       r;
    word_t       pc_val;
    word_t       va;
    word_t       vb;
    reg_idx_t    rj;
    reg_idx_t    rd;
    logic [15:0] off;
    logic [5:0]  op;
    logic        taken;
    r = lcg_next();
    pc_val = lcg_next() & 32'hffff_fffc;
    rj = r[31:27];
    rd = r[21] ? rj : r[26:22];
    off = r[20:5];
    va = rf_mirror[rj];
    vb = rf_mirror[rd];
    case (kind)
      0: begin
        op = `DS_OP_BEQ;
        taken = va == vb;
      end
      1: begin
        op = `DS_OP_BNE;
        taken = va != vb;
      end
      2: begin
        op = `DS_OP_BLT;
        taken = $signed(va) < $signed(vb);
      end
      3: begin
        op = `DS_OP_BGE;
        taken = !($signed(va) < $signed(vb));
      end
      4: begin
        op = `DS_OP_BLTU;
        taken = va < vb;
      end
      5: begin
        op = `DS_OP_BGEU;
        taken = !(va < vb);
      end
      default: begin
        op = `DS_OP_JIRL;
        taken = 1'b1;
      end
    endcase
    load(pc_val, {op, off, rj, rd});
    // fetch offers the next instruction in the branch cycle
    fs_to_ds_valid = 1'b1;
    fs_to_ds = '{pc: pc_val + 32'd4, inst: enc_rr(5'h00, 5'd2, 5'd1, 5'd3)};
    #2;
    check_word("br.taken", br.taken, taken);
    check_word("br.target", br.target,
               ((kind == 6) ? va : pc_val) + {{14{off[15]}}, off, 2'b00});
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
    #2;
    check_word("ds_to_es_valid", ds_to_es_valid, !taken);
  endtask

  task automatic check_backpressure();
    ds_to_es_t held;
    word_t     pc_val;
    pc_val = lcg_next() & 32'hffff_fffc;
    es_allowin = 1'b0;
    load(pc_val, enc_i12(`DS_OP_ALU_IMM, 4'ha, 12'h123, 5'd1, 5'd2));
    fs_to_ds_valid = 1'b1;
    fs_to_ds = '{pc: pc_val + 32'd4, inst: enc_rr(5'h00, 5'd2, 5'd1, 5'd3)};
    #2;
    held = ds_to_es;
    repeat (3) begin
      check_word("ds_allowin", ds_allowin, 1'b0);
      check_word("ds_to_es_valid", ds_to_es_valid, 1'b1);
      check_word("ds_to_es.pc", ds_to_es.pc, pc_val);
      assert (ds_to_es === held) else begin
        $display("[FAIL] ds_to_es: expected %h, got %h", held, ds_to_es);
        fail_stop();
      end
      @(negedge clk);
      #2;
    end
    @(negedge clk);
    es_allowin = 1'b1;
    #2;
    check_word("ds_to_es_valid", ds_to_es_valid, 1'b1);
    check_word("ds_to_es.pc", ds_to_es.pc, pc_val);
    check_word("ds_allowin", ds_allowin, 1'b1);
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
    #2;
    check_word("ds_to_es.pc", ds_to_es.pc, pc_val + 32'd4);
  endtask

  always @(id_stage_i.u_sva.err_cnt) begin
    if (id_stage_i.u_sva.err_cnt != 0) begin
      $display("a concurrent assertion in id_stage_sva failed");
      fail_stop();
    end
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * 8);
    $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    fail_stop();
  end

  initial begin
    int          k;
    word_t       r;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    seed = 32'h5417;
    clk = 1'b0;
    rst_n = 1'b0;
    fs_to_ds_valid = 1'b0;
    fs_to_ds = '0;
    es_allowin = 1'b1;
    clear_sources();
    foreach (rf_mirror[j]) begin
      rf_mirror[j] = '0;
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    #2;
    check_word("ds_to_es_valid", ds_to_es_valid, 1'b0);
    check_word("br.taken", br.taken, 1'b0);
    check_word("ds_allowin", ds_allowin, 1'b1);

    // fill every register through writeback
    for (k = 1; k < `DS_REG_NUM; k++) begin
      @(negedge clk);
      wb = '{we: 1'b1, waddr: reg_idx_t'(k), wdata: lcg_next()};
    end
    @(negedge clk);
    wb = '0;
    check_reads(5'd0, 5'd0);
    for (k = 0; k < N_READS; k++) begin
      r = lcg_next();
      check_reads(r[31:27], r[26:22]);
    end

    r = lcg_next();
    i12 = r[31:20] | 12'h800;
    i16 = r[15:0] | 16'h8000;
    i20 = r[19:0];
    i26 = r[25:0];
    check_decode(enc_i12(`DS_OP_ALU_IMM, 4'ha, i12, 5'd1, 5'd2), {{20{i12[11]}}, i12},
                 12'h001, 1'b1, 1'b1);
    check_decode(enc_i12(`DS_OP_ALU_IMM, 4'he, i12, 5'd1, 5'd2), {20'h0, i12},
                 12'h040, 1'b1, 1'b1);
    check_decode({`DS_OP_LU12I, i20, 5'd3}, {i20, 12'h000}, 12'h800, 1'b1, 1'b1);
    check_decode({`DS_OP_ALU_SHI, 5'h01, 5'd17, 5'd1, 5'd4}, 32'd17, 12'h100, 1'b1, 1'b1);
    check_decode(enc_i12(`DS_OP_MEM, 4'h2, i12, 5'd1, 5'd2), {{20{i12[11]}}, i12},
                 12'h001, 1'b1, 1'b1);
    check_word("load_op", ds_to_es.load_op, 1'b1);
    check_word("store_op", ds_to_es.store_op, 1'b0);
    check_decode(enc_i12(`DS_OP_MEM, 4'h6, i12, 5'd1, 5'd2), {{20{i12[11]}}, i12},
                 12'h001, 1'b1, 1'b0);
    check_word("load_op", ds_to_es.load_op, 1'b0);
    check_word("store_op", ds_to_es.store_op, 1'b1);
    check_decode({`DS_OP_BEQ, i16, 5'd1, 5'd2}, {{14{i16[15]}}, i16, 2'b00},
                 12'h000, 1'b0, 1'b0);
    check_decode(enc_i26(`DS_OP_B, i26), {{4{i26[25]}}, i26, 2'b00}, 12'h000, 1'b0, 1'b0);
    check_decode(enc_i26(`DS_OP_BL, i26), {{4{i26[25]}}, i26, 2'b00}, 12'h001, 1'b0, 1'b1);
    check_word("dest", ds_to_es.dest, `DS_RA_REG);
    check_word("src1_is_pc", ds_to_es.src1_is_pc, 1'b1);
    check_word("src2_is_4", ds_to_es.src2_is_4, 1'b1);

    for (k = 0; k < 8; k++) begin
      check_forward(k[2], k[1], k[0]);
    end
    check_r0_forward();
    check_stall(1'b0);
    check_stall(1'b1);

    for (k = 0; k < N_BRANCH; k++) begin
      check_branch(k % 7);
    end
    check_backpressure();

    @(negedge clk);
    if (id_stage_i.u_sva.err_cnt != 0) begin
      $display("concurrent assertions failed %0d times", id_stage_i.u_sva.err_cnt);
      fail_stop();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- tb/id_stage_sva.sv
`timescale 1ns/10ps

module id_stage_sva import ds_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      fs_to_ds_valid,
  input fs_to_ds_t fs_to_ds,
  input logic      es_allowin,
  input logic      ds_allowin,
  input logic      ds_to_es_valid,
  input ds_to_es_t ds_to_es,
  input br_t       br,
  input logic      ds_valid,
  input logic      stall,
  input fs_to_ds_t ds_bus
);

  int unsigned err_cnt = 0;

  // comes out of reset empty and open
  a_reset: assert property (@(posedge clk) !rst_n |=> !ds_to_es_valid && !br.taken && ds_allowin)
    else begin
      err_cnt++;
      $error("stage not empty and open after reset");
    end

  // an accepted instruction sits in the stage from the accept edge on
  a_accept: assert property (@(posedge clk) disable iff (!rst_n)
    fs_to_ds_valid && ds_allowin && !br.taken |=> ds_valid && ds_bus == $past(fs_to_ds))
    else begin
      err_cnt++;
      $error("accepted instruction was not loaded into the stage");
    end

  // a taken branch kills the stage
  a_taken_kill: assert property (@(posedge clk) disable iff (!rst_n)
    br.taken |=> !ds_valid)
    else begin
      err_cnt++;
      $error("stage still valid after a taken branch");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ds_valid && stall |=> ds_valid && $stable(ds_bus))
    else begin
      err_cnt++;
      $error("stalled instruction was not held");
    end

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    ds_to_es_valid && !es_allowin && !br.taken |=> ds_to_es_valid && $stable(ds_to_es))
    else begin
      err_cnt++;
      $error("payload changed under back-pressure");
    end

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/10ps

module id_stage import ds_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      fs_to_ds_valid,
  input  fs_to_ds_t fs_to_ds,
  output logic      ds_allowin,
  output logic      ds_to_es_valid,
  output ds_to_es_t ds_to_es,
  input  logic      es_allowin,
  output br_t       br,
  input  wb_t       wb,
  input  fwd_t      es_fwd,
  input  fwd_t      ms_fwd
);

  logic      ds_valid;
  fs_to_ds_t ds_bus;
  dec_t      dec;
  word_t     rdata1;
  word_t     rdata2;
  word_t     rj_value;
  word_t     rkd_value;
  logic      stall;

  assign ds_to_es_valid = ds_valid && !stall;

  ds_latch u_latch (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (fs_to_ds_valid),
    .in_bus     (fs_to_ds),
    .es_allowin (es_allowin),
    .stall      (stall),
    .br_taken   (br.taken),
    .ds_allowin (ds_allowin),
    .ds_valid   (ds_valid),
    .ds_bus     (ds_bus)
  );

  inst_decoder u_dec (
    .inst (ds_bus.inst),
    .dec  (dec)
  );

  regfile u_regfile (
    .clk    (clk),
    .raddr1 (dec.raddr1),
    .raddr2 (dec.raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

  operand_forward u_fwd (
    .raddr1    (dec.raddr1),
    .raddr2    (dec.raddr2),
    .need_rj   (dec.need_rj),
    .need_rkd  (dec.need_rkd),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .es_fwd    (es_fwd),
    .ms_fwd    (ms_fwd),
    .wb        (wb),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .stall     (stall)
  );

  // resolve only once the operands are final
  branch_resolve u_br (
    .ds_valid  (ds_to_es_valid),
    .pc        (ds_bus.pc),
    .dec       (dec),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .br        (br)
  );

  always_comb begin
    ds_to_es.alu_op      = dec.alu_op;
    ds_to_es.load_op     = dec.load_op;
    ds_to_es.src1_is_pc  = dec.src1_is_pc;
    ds_to_es.src2_is_imm = dec.src2_is_imm;
    ds_to_es.src2_is_4   = dec.src2_is_4;
    ds_to_es.gr_we       = dec.gr_we;
    ds_to_es.store_op    = dec.store_op;
    ds_to_es.dest        = dec.dest;
    ds_to_es.imm         = dec.imm;
    ds_to_es.rj_value    = rj_value;
    ds_to_es.rkd_value   = rkd_value;
    ds_to_es.pc          = ds_bus.pc;
  end

endmodule

//--- rtl/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve import ds_pkg::*; (
  input  logic  ds_valid,
  input  word_t pc,
  input  dec_t  dec,
  input  word_t rj_value,
  input  word_t rkd_value,
  output br_t   br
);

  logic rj_eq_rd;
  logic rj_lt_rd_sign;
  logic rj_lt_rd_unsign;
  logic cmp;
  logic cond_hold;

  assign rj_eq_rd        = rj_value == rkd_value;
  assign rj_lt_rd_unsign = rj_value < rkd_value;
  assign rj_lt_rd_sign   = $signed(rj_value) < $signed(rkd_value);

  always_comb begin
    case (dec.br_cond[2:1])
      2'b01:   cmp = rj_eq_rd;
      2'b10:   cmp = rj_lt_rd_sign;
      2'b11:   cmp = rj_lt_rd_unsign;
      default: cmp = 1'b0;
    endcase
  end

  // bne, bge, bgeu take the inverted compare
  assign cond_hold = (dec.br_cond[2:1] != 2'b00) && (cmp ^ dec.br_cond[0]);

  assign br.taken  = ds_valid && (cond_hold || dec.jump);
  assign br.target = (dec.jirl ? rj_value : pc) + dec.imm;

endmodule

//--- rtl/operand_forward.sv
`timescale 1ns/10ps
`include "ds_macros.svh"

module operand_forward import ds_pkg::*; (
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  input  logic     need_rj,
  input  logic     need_rkd,
  input  word_t    rdata1,
  input  word_t    rdata2,
  input  fwd_t     es_fwd,
  input  fwd_t     ms_fwd,
  input  wb_t      wb,
  output word_t    rj_value,
  output word_t    rkd_value,
  output logic     stall
);

  logic stall1;
  logic stall2;

  // returns {busy, data} from the youngest producer of addr
  function automatic logic [`DS_WORD_WD:0] pick(input reg_idx_t addr, input logic need,
                                                input word_t rf_data, input fwd_t es,
                                                input fwd_t ms, input wb_t w);
    logic hit_ok;
    hit_ok = need && (addr != '0);
    if (hit_ok && es.enable && es.dest == addr) begin
      pick = {es.busy, es.data};
    end else if (hit_ok && ms.enable && ms.dest == addr) begin
      pick = {ms.busy, ms.data};
    end else if (hit_ok && w.we && w.waddr == addr) begin
      pick = {1'b0, w.wdata};
    end else begin
      pick = {1'b0, rf_data};
    end
  endfunction

  assign {stall1, rj_value}  = pick(raddr1, need_rj, rdata1, es_fwd, ms_fwd, wb);
  assign {stall2, rkd_value} = pick(raddr2, need_rkd, rdata2, es_fwd, ms_fwd, wb);
  assign stall = stall1 | stall2;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/10ps
`include "ds_macros.svh"

module regfile import ds_pkg::*; (
  input  logic     clk,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  output word_t    rdata1,
  output word_t    rdata2,
  input  wb_t      wb
);

  word_t mem [`DS_REG_NUM];

  always_ff @(posedge clk) begin
    if (wb.we && wb.waddr != '0) begin
      mem[wb.waddr] <= wb.wdata;
    end
  end

  // r0 is hardwired
  assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

//--- rtl/inst_decoder.sv
`timescale 1ns/10ps
`include "ds_macros.svh"

module inst_decoder import ds_pkg::*; (
  input  inst_t inst,
  output dec_t  dec
);

  logic [3:0]  op_25_22;
  logic [4:0]  op_19_15;
  reg_idx_t    rd, rj, rk;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;
  logic        is_rr, is_shi, is_imm, is_mem;
  logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
  logic        inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
  logic        inst_slli_w, inst_srli_w, inst_srai_w;
  logic        inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
  logic        inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
  logic        inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  logic        inst_b, inst_bl, inst_jirl;
  logic        alu_rr, alu_shi, alu_imm, cond_br;

  assign op_25_22 = inst[25:22];
  assign op_19_15 = inst[19:15];
  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i16 = inst[25:10];
  assign i20 = inst[24:5];
  assign i26 = {inst[9:0], inst[25:10]};

  assign is_rr  = inst[31:20] == `DS_OP_ALU_RR;
  assign is_shi = inst[31:20] == `DS_OP_ALU_SHI;
  assign is_imm = inst[31:26] == `DS_OP_ALU_IMM;
  assign is_mem = inst[31:26] == `DS_OP_MEM;

  assign inst_add_w  = is_rr && op_19_15 == 5'h00;
  assign inst_sub_w  = is_rr && op_19_15 == 5'h02;
  assign inst_slt    = is_rr && op_19_15 == 5'h04;
  assign inst_sltu   = is_rr && op_19_15 == 5'h05;
  assign inst_nor    = is_rr && op_19_15 == 5'h08;
  assign inst_and    = is_rr && op_19_15 == 5'h09;
  assign inst_or     = is_rr && op_19_15 == 5'h0a;
  assign inst_xor    = is_rr && op_19_15 == 5'h0b;
  assign inst_sll_w  = is_rr && op_19_15 == 5'h0e;
  assign inst_srl_w  = is_rr && op_19_15 == 5'h0f;
  assign inst_sra_w  = is_rr && op_19_15 == 5'h10;
  assign inst_slli_w = is_shi && op_19_15 == 5'h01;
  assign inst_srli_w = is_shi && op_19_15 == 5'h09;
  assign inst_srai_w = is_shi && op_19_15 == 5'h11;
  assign inst_slti   = is_imm && op_25_22 == 4'h8;
  assign inst_sltui  = is_imm && op_25_22 == 4'h9;
  assign inst_addi_w = is_imm && op_25_22 == 4'ha;
  assign inst_andi   = is_imm && op_25_22 == 4'hd;
  assign inst_ori    = is_imm && op_25_22 == 4'he;
  assign inst_xori   = is_imm && op_25_22 == 4'hf;
  assign inst_ld_w   = is_mem && op_25_22 == 4'h2;
  assign inst_st_w   = is_mem && op_25_22 == 4'h6;
  assign inst_jirl   = inst[31:26] == `DS_OP_JIRL;
  assign inst_b      = inst[31:26] == `DS_OP_B;
  assign inst_bl     = inst[31:26] == `DS_OP_BL;
  assign inst_beq    = inst[31:26] == `DS_OP_BEQ;
  assign inst_bne    = inst[31:26] == `DS_OP_BNE;
  assign inst_blt    = inst[31:26] == `DS_OP_BLT;
  assign inst_bge    = inst[31:26] == `DS_OP_BGE;
  assign inst_bltu   = inst[31:26] == `DS_OP_BLTU;
  assign inst_bgeu   = inst[31:26] == `DS_OP_BGEU;
  assign inst_lu12i_w   = inst[31:25] == `DS_OP_LU12I;
  assign inst_pcaddu12i = inst[31:25] == `DS_OP_PCADDU;

  assign alu_rr  = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and |
                   inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
  assign alu_shi = inst_slli_w | inst_srli_w | inst_srai_w;
  assign alu_imm = inst_addi_w | inst_slti | inst_sltui | inst_andi | inst_ori | inst_xori;
  assign cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

  always_comb begin
    // address math for memory and link also goes through add
    dec.alu_op[0]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | inst_jirl |
                     inst_bl | inst_pcaddu12i;
    dec.alu_op[1]  = inst_sub_w;
    dec.alu_op[2]  = inst_slt | inst_slti;
    dec.alu_op[3]  = inst_sltu | inst_sltui;
    dec.alu_op[4]  = inst_and | inst_andi;
    dec.alu_op[5]  = inst_nor;
    dec.alu_op[6]  = inst_or | inst_ori;
    dec.alu_op[7]  = inst_xor | inst_xori;
    dec.alu_op[8]  = inst_sll_w | inst_slli_w;
    dec.alu_op[9]  = inst_srl_w | inst_srli_w;
    dec.alu_op[10] = inst_sra_w | inst_srai_w;
    dec.alu_op[11] = inst_lu12i_w;

    dec.load_op     = inst_ld_w;
    dec.store_op    = inst_st_w;
    dec.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
    dec.src2_is_imm = alu_shi | alu_imm | inst_lu12i_w | inst_pcaddu12i | inst_ld_w | inst_st_w;
    dec.src2_is_4   = inst_jirl | inst_bl;
    dec.gr_we       = alu_rr | alu_shi | alu_imm | inst_lu12i_w | inst_pcaddu12i |
                      inst_ld_w | inst_jirl | inst_bl;
    dec.dest        = inst_bl ? `DS_RA_REG : rd;
    dec.need_rj     = alu_rr | alu_shi | alu_imm | cond_br | inst_jirl | inst_ld_w | inst_st_w;
    dec.need_rkd    = alu_rr | cond_br | inst_st_w;
    dec.raddr1      = rj;
    dec.raddr2      = (cond_br | inst_st_w) ? rd : rk;

    dec.br_cond = {inst_blt | inst_bge | inst_bltu | inst_bgeu,
                   inst_beq | inst_bne | inst_bltu | inst_bgeu,
                   inst_bne | inst_bge | inst_bgeu};
    dec.jump    = inst_b | inst_bl | inst_jirl;
    dec.jirl    = inst_jirl;

    // immediate by format
    if (alu_shi) begin
      dec.imm = {27'b0, rk};
    end else if (inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w) begin
      dec.imm = {{20{i12[11]}}, i12};
    end else if (inst_andi | inst_ori | inst_xori) begin
      dec.imm = {20'b0, i12};
    end else if (cond_br | inst_jirl) begin
      dec.imm = {{14{i16[15]}}, i16, 2'b0};
    end else if (inst_lu12i_w | inst_pcaddu12i) begin
      dec.imm = {i20, 12'b0};
    end else if (inst_b | inst_bl) begin
      dec.imm = {{4{i26[25]}}, i26, 2'b0};
    end else begin
      dec.imm = '0;
    end
  end

endmodule

//--- rtl/ds_latch.sv
`timescale 1ns/10ps

module ds_latch import ds_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  fs_to_ds_t in_bus,
  input  logic      es_allowin,
  input  logic      stall,
  input  logic      br_taken,
  output logic      ds_allowin,
  output logic      ds_valid,
  output fs_to_ds_t ds_bus
);

  // empty, or the held instruction leaves this cycle
  assign ds_allowin = !ds_valid || (es_allowin && !stall);

  always_ff @(posedge clk) begin
    if (!rst_n || br_taken) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && ds_allowin) begin
      ds_bus <= in_bus;
    end
  end

endmodule

//--- rtl/ds_pkg.sv
`include "ds_macros.svh"

package ds_pkg;

  typedef logic [`DS_WORD_WD-1:0]    word_t;
  typedef logic [`DS_REG_IDX_WD-1:0] reg_idx_t;
  typedef logic [`DS_WORD_WD-1:0]    inst_t;
  // one-hot: add sub slt sltu and nor or xor sll srl sra lui, from bit 0 up
  typedef logic [`DS_ALU_OP_WD-1:0]  alu_op_t;

  typedef struct packed {
    word_t pc;
    inst_t inst;
  } fs_to_ds_t;

  typedef struct packed {
    logic     we;
    reg_idx_t waddr;
    word_t    wdata;
  } wb_t;

  typedef struct packed {
    logic     busy;
    logic     enable;
    reg_idx_t dest;
    word_t    data;
  } fwd_t;

  // br_cond[2:1] picks the compare (01 eq, 10 signed lt, 11 unsigned lt, 00 none)
  // br_cond[0] inverts it
  typedef struct packed {
    alu_op_t    alu_op;
    logic       load_op;
    logic       store_op;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       src2_is_4;
    logic       gr_we;
    reg_idx_t   dest;
    word_t      imm;
    logic       need_rj;
    logic       need_rkd;
    reg_idx_t   raddr1;
    reg_idx_t   raddr2;
    logic [2:0] br_cond;
    logic       jump;
    logic       jirl;
  } dec_t;

  typedef struct packed {
    alu_op_t  alu_op;
    logic     load_op;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     src2_is_4;
    logic     gr_we;
    logic     store_op;
    reg_idx_t dest;
    word_t    imm;
    word_t    rj_value;
    word_t    rkd_value;
    word_t    pc;
  } ds_to_es_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } br_t;

endpackage

//--- include/ds_macros.svh
`ifndef DS_MACROS_SVH
`define DS_MACROS_SVH

`define DS_WORD_WD    32
`define DS_REG_NUM    32
`define DS_REG_IDX_WD 5
`define DS_ALU_OP_WD  12
`define DS_RA_REG     5'd1

// compared against inst[31:20]
`define DS_OP_ALU_RR  12'h001
`define DS_OP_ALU_SHI 12'h004
// compared against inst[31:26]
`define DS_OP_ALU_IMM 6'h00
`define DS_OP_MEM     6'h0a
`define DS_OP_JIRL    6'h13
`define DS_OP_B       6'h14
`define DS_OP_BL      6'h15
`define DS_OP_BEQ     6'h16
`define DS_OP_BNE     6'h17
`define DS_OP_BLT     6'h18
`define DS_OP_BGE     6'h19
`define DS_OP_BLTU    6'h1a
`define DS_OP_BGEU    6'h1b
// compared against inst[31:25]
`define DS_OP_LU12I   7'h0a
`define DS_OP_PCADDU  7'h0e

`endif
